// File: src.f
rtl/filter_pkg.sv
rtl/seq_pkg.sv
rtl/sample_rate_timer.sv
rtl/biquad_sequencer.sv
rtl/biquad_datapath.sv
rtl/mac_accum.sv
rtl/biquad_section.sv
rtl/iir_cascade_top.sv
sim/iir_cascade_asserts.sv
sim/tb_iir_cascade.sv

// File: Makefile
TOP := tb_iir_cascade

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f src.f -o $(TOP)

# Pass only if the testbench printed its pass line
run: compile
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: sim/tb_iir_cascade.sv
// Testbench for the biquad cascade: clock, reset, stimulus phases, timeout, pass/fail
`timescale 1ns/100ps

module tb_iir_cascade
    import filter_pkg::*;
();

    localparam int SAMPLE_DIV  = 16;
    localparam int N_SAMPLES   = 40;    // Per phase
    localparam int CYCLE_LIMIT = 6 * N_SAMPLES * SAMPLE_DIV + 400;

    // Q2.14 sets in order b0, b1, b2, a1, a2
    localparam biquad_coef_t COEF_PASS = '{16'sd16384, 16'sd0, 16'sd0, 16'sd0, 16'sd0};
    localparam biquad_coef_t COEF_LP1  = '{16'sd1106, 16'sd2212, 16'sd1106, -16'sd18727, 16'sd6763};
    localparam biquad_coef_t COEF_LP2  = '{16'sd2621, 16'sd5243, 16'sd2621, -16'sd13107, 16'sd7208};
    localparam biquad_coef_t COEF_WRAP = '{16'sh8000, 16'sd32767, 16'sd0, 16'sh8000, 16'sd0};

    logic         clk = 1'b0;
    logic         reset;
    logic         run;
    sample_t      sample_in;
    biquad_coef_t coef_s1;
    biquad_coef_t coef_s2;
    logic         sample_req;
    sample_t      filt_out;
    logic         out_valid;
    integer       seed = 32'h5ffb;
    int           cycle_cnt = 0;
    int           pending = 0;      // Requests whose result is still due

    always #5 clk = ~clk;   // 10 ns period

    iir_cascade_top #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .sample_in  (sample_in),
        .coef_s1    (coef_s1),
        .coef_s2    (coef_s2),
        .sample_req (sample_req),
        .filt_out   (filt_out),
        .out_valid  (out_valid)
    );

    // Reference model and assertions live inside the DUT top
    bind iir_cascade_top iir_cascade_asserts #(.SAMPLE_DIV(SAMPLE_DIV)) u_asserts (.*);

    task automatic report_fail(input string reason);
        $display("** FAIL **");
        $fatal(1, "%s", reason);
    endtask

    // Returns on the edge that samples sample_req high
    task automatic wait_req();
        @(posedge clk);
        while (!sample_req)
            @(posedge clk);
    endtask

    task automatic feed_samples(input int n, input int shift);
        for (int i = 0; i < n; i++) begin
            wait_req();
            sample_in <= sample_t'($random(seed)) >>> shift;   // Next request takes it
        end
    endtask

    // Feedback kept within +-0.5
    function automatic biquad_coef_t random_coef();
        biquad_coef_t c;
        c.b0 = sample_t'($random(seed)) >>> 1;
        c.b1 = sample_t'($random(seed)) >>> 1;
        c.b2 = sample_t'($random(seed)) >>> 1;
        c.a1 = sample_t'($random(seed)) >>> 2;
        c.a2 = sample_t'($random(seed)) >>> 2;
        return c;
    endfunction

    // Coefficients move at a random clock inside each sample period
    task automatic feed_with_coef_changes(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            wait_req();
            sample_in <= sample_t'($random(seed)) >>> 2;
            gap = {$random(seed)} % 14;
            repeat (gap + 1) @(posedge clk);
            coef_s1 <= random_coef();
            coef_s2 <= random_coef();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            report_fail("timeout: stimulus did not finish within the cycle limit");
    end

    // Results owed by the DUT, dropped with it on reset
    always @(posedge clk) begin
        if (!reset)
            pending <= 0;
        else
            pending <= pending + int'(sample_req) - int'(out_valid);
    end

    always @(posedge clk) begin
        if (i_dut.u_asserts.fail_flag)
            report_fail("checker assertion failed, see the mismatch line above");
    end

    initial begin
        reset     = 1'b0;
        run       = 1'b0;
        sample_in = '0;
        coef_s1   = COEF_PASS;
        coef_s2   = COEF_PASS;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        run   <= 1'b1;
        feed_samples(N_SAMPLES, 0);     // Pass-through, full scale
        coef_s1 <= COEF_LP1;
        coef_s2 <= COEF_LP2;
        feed_samples(N_SAMPLES, 2);     // Low-pass with feedback
        for (int i = 0; i < 4; i++) begin
            feed_samples(N_SAMPLES / 4, 2);
            run <= 1'b0;                // Timer parked, requests must stop
            repeat (24) @(posedge clk);
            run <= 1'b1;
        end
        feed_with_coef_changes(N_SAMPLES);
        coef_s1 <= COEF_LP1;
        coef_s2 <= COEF_LP2;
        wait_req();
        repeat (6) @(posedge clk);      // Section 1 mid-pass, section 2 still to come
        reset     <= 1'b0;
        sample_in <= 16'sd8192;         // Impulse for the first request after reset
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        wait_req();
        sample_in <= '0;
        repeat (N_SAMPLES - 1) wait_req();
        coef_s1 <= COEF_WRAP;           // Negation and sum wrap corners
        coef_s2 <= COEF_LP2;
        feed_samples(N_SAMPLES, 0);
        run <= 1'b0;
        @(posedge clk);
        while (pending != 0)            // Last results still in flight
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (i_dut.u_asserts.fail_flag) begin
            report_fail("checker assertion failed before the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: sim/iir_cascade_asserts.sv
// Bound checker with two-section reference model and timing, value and reset assertions
`timescale 1ns/100ps

module iir_cascade_asserts
    import filter_pkg::*;
#(
    parameter int SAMPLE_DIV = 16
) (
    input logic         clk,
    input logic         reset,
    input logic         run,
    input logic         sample_req,
    input sample_t      sample_in,
    input biquad_coef_t coef_s1,
    input biquad_coef_t coef_s2,
    input sample_t      filt_out,
    input logic         out_valid
);

    localparam int LAT = 17;    // sample_req to out_valid

    // History one section carries into its next pass
    typedef struct packed {
        sample_t x1;
        sample_t x2;
        sample_t y1;
        sample_t y2;
    } hist_t;

    logic           fail_flag = 1'b0;   // Watched by the testbench
    logic [LAT-1:0] req_pipe;           // Bit i is sample_req i+1 clocks back
    int             run_cnt;            // Clocks in a row with run high
    logic           exp_req;
    sample_t        x_req;              // Sample taken with the request
    hist_t          h1, h2;
    sample_t        exp_y1, exp_y2;

    // b0 x + b1 x1 + b2 x2 - a1 y1 - a2 y2 in Q4.28
    // Half an output LSB added, then shifted down to Q2.14
    function automatic sample_t section_ref(biquad_coef_t c, sample_t x, hist_t h);
        sample_t neg_a1;
        sample_t neg_a2;
        acc_t    sum;
        acc_t    half;
        neg_a1 = -c.a1;     // 16-bit negate, -32768 stays put
        neg_a2 = -c.a2;
        sum = c.b0 * x + c.b1 * h.x1 + c.b2 * h.x2 + neg_a1 * h.y1 + neg_a2 * h.y2;
        half = acc_t'(1 << (FRAC_BITS - 1));
        return sample_t'((sum + half) >>> FRAC_BITS);  // Low 16 bits kept, wraps
    endfunction

    // Request every SAMPLE_DIV clocks of uninterrupted run
    assign exp_req = (run_cnt != 0) && (run_cnt % SAMPLE_DIV == 0);

    always @(posedge clk) begin : ref_model
        sample_t y1_new;
        sample_t y2_new;
        if (!reset) begin
            req_pipe <= '0;
            run_cnt  <= 0;
            h1       <= '0;
            h2       <= '0;
            exp_y1   <= '0;
            exp_y2   <= '0;
        end else begin
            req_pipe <= {req_pipe[LAT-2:0], sample_req};
            run_cnt  <= run ? run_cnt + 1 : 0;
            if (sample_req)
                x_req <= sample_in;
            if (req_pipe[0]) begin  // Section 1 trigger, coef_s1 taken here
                y1_new = section_ref(coef_s1, x_req, h1);
                h1     <= '{x1: x_req, x2: h1.x1, y1: y1_new, y2: h1.y1};
                exp_y1 <= y1_new;
            end
            if (req_pipe[8]) begin  // Section 2 trigger, 8 clocks later
                y2_new = section_ref(coef_s2, exp_y1, h2);
                h2     <= '{x1: exp_y1, x2: h2.x1, y1: y2_new, y2: h2.y1};
                exp_y2 <= y2_new;
            end
        end
    end

    a_req_period: assert property (@(posedge clk) disable iff (!reset) sample_req == exp_req)
    else begin
        fail_flag = 1'b1;
        $error("mismatch at %0t: sample_req dut=%0b exp=%0b", $time,
            $sampled(sample_req), $sampled(exp_req));
    end

    a_out_timing: assert property (@(posedge clk) disable iff (!reset)
        out_valid == req_pipe[LAT-1])
    else begin
        fail_flag = 1'b1;
        $error("mismatch at %0t: out_valid dut=%0b exp=%0b", $time,
            $sampled(out_valid), $sampled(req_pipe[LAT-1]));
    end

    a_out_single: assert property (@(posedge clk) disable iff (!reset) out_valid |=> !out_valid)
    else begin
        fail_flag = 1'b1;
        $error("mismatch at %0t: out_valid second cycle dut=%0b exp=0", $time,
            $sampled(out_valid));
    end

    a_out_value: assert property (@(posedge clk) disable iff (!reset)
        req_pipe[LAT-1] |-> filt_out == exp_y2)
    else begin
        fail_flag = 1'b1;
        $error("mismatch at %0t: filt_out dut=%0d exp=%0d", $time,
            $sampled(filt_out), $sampled(exp_y2));
    end

    a_reset_clear: assert property (@(posedge clk) $rose(reset) |-> !out_valid && filt_out == '0)
    else begin
        fail_flag = 1'b1;
        $error("mismatch at %0t: after reset out_valid dut=%0b exp=0, filt_out dut=%0d exp=0",
            $time, $sampled(out_valid), $sampled(filt_out));
    end

endmodule

// File: rtl/iir_cascade_top.sv
// Two-section cascaded biquad filter with sample-rate timer and input capture
`timescale 1ns/100ps

module iir_cascade_top
    import filter_pkg::*;
#(
    parameter int SAMPLE_DIV = 16   // Clocks per sample
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         run,
    input  sample_t      sample_in,
    input  biquad_coef_t coef_s1,
    input  biquad_coef_t coef_s2,
    output logic         sample_req,    // Upstream presents next sample
    output sample_t      filt_out,
    output logic         out_valid      // 17 cycles after sample_req
);

    sample_t x_capt;    // Input sample held for section 1
    logic    trig1;     // sample_req delayed one cycle
    sample_t s1_y;
    logic    s1_valid;

    sample_rate_timer #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_timer (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .sample_req (sample_req)
    );

    always_ff @(posedge clk) begin
        if (sample_req)
            x_capt <= sample_in;
    end

    // Trigger lines up with x_capt
    always_ff @(posedge clk) begin
        if (!reset)
            trig1 <= 1'b0;
        else
            trig1 <= sample_req;
    end

    biquad_section u_sec1 (
        .clk     (clk),
        .reset   (reset),
        .trigger (trig1),
        .sample  (x_capt),
        .coef    (coef_s1),
        .y       (s1_y),
        .y_valid (s1_valid)
    );

    // Section 2 runs off section 1's result strobe
    biquad_section u_sec2 (
        .clk     (clk),
        .reset   (reset),
        .trigger (s1_valid),
        .sample  (s1_y),
        .coef    (coef_s2),
        .y       (filt_out),
        .y_valid (out_valid)
    );

endmodule

// File: rtl/biquad_section.sv
// One biquad section: sequencer, datapath and shared MAC
`timescale 1ns/100ps

module biquad_section
    import filter_pkg::*;
    import seq_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         trigger,   // y_valid follows 8 cycles later
    input  sample_t      sample,
    input  biquad_coef_t coef,
    output sample_t      y,
    output logic         y_valid
);

    logic     capture;
    tap_sel_t tap_sel;
    mac_op_t  mac_op;
    logic     round_en;
    sample_t  mac_coef;
    sample_t  mac_data;
    acc_t     acc;

    biquad_sequencer u_seq (
        .clk      (clk),
        .reset    (reset),
        .trigger  (trigger),
        .capture  (capture),
        .tap_sel  (tap_sel),
        .mac_op   (mac_op),
        .round_en (round_en)
    );

    biquad_datapath u_dp (
        .clk      (clk),
        .reset    (reset),
        .sample   (sample),
        .coef     (coef),
        .capture  (capture),
        .tap_sel  (tap_sel),
        .round_en (round_en),
        .acc      (acc),
        .mac_coef (mac_coef),
        .mac_data (mac_data),
        .y        (y),
        .y_valid  (y_valid)
    );

    mac_accum u_mac (
        .clk    (clk),
        .reset  (reset),
        .mac_op (mac_op),
        .coef   (mac_coef),
        .data   (mac_data),
        .acc    (acc)
    );

endmodule

// File: rtl/mac_accum.sv
// Two-stage signed multiply-accumulate, product register then accumulator
`timescale 1ns/100ps

module mac_accum
    import filter_pkg::*;
    import seq_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  mac_op_t mac_op,
    input  sample_t coef,   // Q2.14 coefficient
    input  sample_t data,   // Q2.14 sample
    output acc_t    acc     // Q4.28 running sum
);

    acc_t    prod_r;    // Stage 1 product
    mac_op_t op_r;      // Opcode travelling with its product

    // Stage 1, multiplier register
    always_ff @(posedge clk) begin
        prod_r <= coef * data;  // Both signed, extended to 32 bits
    end

    always_ff @(posedge clk) begin
        if (!reset)
            op_r <= MAC_HOLD;
        else
            op_r <= mac_op;
    end

    // Stage 2, accumulator
    always_ff @(posedge clk) begin
        if (!reset) begin
            acc <= '0;
        end else begin
            case (op_r)
                MAC_LOAD: acc <= prod_r;
                MAC_ACC:  acc <= acc + prod_r;     // Wraps on overflow
                default:  acc <= acc;              // MAC_HOLD
            endcase
        end
    end

endmodule

// File: rtl/biquad_datapath.sv
// Biquad history registers, coefficient latch, tap mux and rounded output register
`timescale 1ns/100ps

module biquad_datapath
    import filter_pkg::*;
    import seq_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  sample_t      sample,    // x[n] from upstream
    input  biquad_coef_t coef,
    input  logic         capture,
    input  tap_sel_t     tap_sel,
    input  logic         round_en,
    input  acc_t         acc,       // Q4.28 sum from the MAC
    output sample_t      mac_coef,
    output sample_t      mac_data,
    output sample_t      y,
    output logic         y_valid
);

    sample_t x_n, x_n1, x_n2;   // Input history
    sample_t y_n1, y_n2;        // Output history
    biquad_coef_t coef_r;       // Held for the whole pass

    always_ff @(posedge clk) begin
        if (!reset) begin
            x_n  <= '0;
            x_n1 <= '0;
            x_n2 <= '0;
            y_n1 <= '0;
            y_n2 <= '0;
        end else if (capture) begin
            x_n  <= sample;
            x_n1 <= x_n;
            x_n2 <= x_n1;
            y_n1 <= y;      // Last result becomes y[n-1]
            y_n2 <= y_n1;
        end
    end

    // Coefficients sampled with the trigger, later changes wait for next sample
    always_ff @(posedge clk) begin
        if (capture)
            coef_r <= coef;
    end

    // Tap mux, feedback terms negated (wraps at -32768)
    always_comb begin
        case (tap_sel)
            SEL_B0: begin
                mac_coef = coef_r.b0;
                mac_data = x_n;
            end
            SEL_B1: begin
                mac_coef = coef_r.b1;
                mac_data = x_n1;
            end
            SEL_B2: begin
                mac_coef = coef_r.b2;
                mac_data = x_n2;
            end
            SEL_A1: begin
                mac_coef = -coef_r.a1;
                mac_data = y_n1;
            end
            SEL_A2: begin
                mac_coef = -coef_r.a2;
                mac_data = y_n2;
            end
            default: begin
                mac_coef = '0;
                mac_data = '0;
            end
        endcase
    end

    // Q4.28 to Q2.14, round half up on bit FRAC_BITS-1, overflow wraps
    always_ff @(posedge clk) begin
        if (!reset) begin
            y       <= '0;
            y_valid <= 1'b0;
        end else begin
            y_valid <= round_en;
            if (round_en)
                y <= sample_t'(acc[FRAC_BITS +: SAMPLE_W] + SAMPLE_W'(acc[FRAC_BITS-1]));
        end
    end

endmodule

// File: rtl/biquad_sequencer.sv
// Biquad section FSM driving sample capture, tap select, MAC opcode and rounding
`timescale 1ns/100ps

module biquad_sequencer
    import seq_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     trigger,   // New sample ready, one cycle
    output logic     capture,   // Latch sample, coefficients, history
    output tap_sel_t tap_sel,
    output mac_op_t  mac_op,
    output logic     round_en   // Accumulator final this cycle
);

    seq_state_t state, next_state;

    always_ff @(posedge clk) begin
        if (!reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    // Fixed walk through the taps; trigger only seen in IDLE
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (trigger) next_state = TAP_B0;
            TAP_B0:  next_state = TAP_B1;
            TAP_B1:  next_state = TAP_B2;
            TAP_B2:  next_state = TAP_A1;
            TAP_A1:  next_state = TAP_A2;
            TAP_A2:  next_state = DRAIN1;
            DRAIN1:  next_state = DRAIN2;
            DRAIN2:  next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Trigger while busy is dropped
    assign capture  = (state == IDLE) && trigger;
    assign round_en = (state == DRAIN2);

    // Tap and opcode decode
    always_comb begin
        tap_sel = SEL_B0;
        mac_op  = MAC_HOLD;     // IDLE and drain states
        case (state)
            TAP_B0: begin
                tap_sel = SEL_B0;
                mac_op  = MAC_LOAD; // First product starts a fresh sum
            end
            TAP_B1: begin
                tap_sel = SEL_B1;
                mac_op  = MAC_ACC;
            end
            TAP_B2: begin
                tap_sel = SEL_B2;
                mac_op  = MAC_ACC;
            end
            TAP_A1: begin
                tap_sel = SEL_A1;
                mac_op  = MAC_ACC;
            end
            TAP_A2: begin
                tap_sel = SEL_A2;
                mac_op  = MAC_ACC;
            end
            default: begin
                tap_sel = SEL_B0;
                mac_op  = MAC_HOLD;
            end
        endcase
    end

endmodule

// File: rtl/sample_rate_timer.sv
// Sample-rate divider producing a one-cycle sample request strobe
`timescale 1ns/100ps

module sample_rate_timer #(
    parameter int SAMPLE_DIV = 16   // Clocks per sample, at least 9
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic sample_req
);

    localparam int CNT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SAMPLE_DIV - 1);

    logic [CNT_W-1:0] cnt;  // Down-counter, reloads at zero

    always_ff @(posedge clk) begin
        if (!reset) begin
            cnt        <= RELOAD;
            sample_req <= 1'b0;
        end else if (!run) begin
            cnt        <= RELOAD;   // Parked, first pulse SAMPLE_DIV after run rises
            sample_req <= 1'b0;
        end else if (cnt == '0) begin
            cnt        <= RELOAD;
            sample_req <= 1'b1;     // One pulse per period
        end else begin
            cnt        <= cnt - 1'b1;
            sample_req <= 1'b0;
        end
    end

endmodule

// File: rtl/seq_pkg.sv
// Sequencer state, MAC opcode and tap-select enums
package seq_pkg;

    // One pass of a section: five taps, then two cycles of MAC drain
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        TAP_B0 = 3'd1,
        TAP_B1 = 3'd2,
        TAP_B2 = 3'd3,
        TAP_A1 = 3'd4,
        TAP_A2 = 3'd5,
        DRAIN1 = 3'd6,  // Last product moving into accumulator
        DRAIN2 = 3'd7   // Accumulator final, round and capture
    } seq_state_t;

    typedef enum logic [1:0] {
        MAC_HOLD = 2'd0,    // Keep accumulator
        MAC_LOAD = 2'd1,    // Product replaces accumulator
        MAC_ACC  = 2'd2     // Product added to accumulator
    } mac_op_t;

    // Which coefficient / data pair goes to the MAC
    typedef enum logic [2:0] {
        SEL_B0, SEL_B1, SEL_B2, SEL_A1, SEL_A2
    } tap_sel_t;

endpackage

// File: rtl/filter_pkg.sv
// Word widths, Q-format constants, sample, accumulator and coefficient types
package filter_pkg;

    // Audio sample and coefficient word
    localparam int SAMPLE_W = 16;

    // Accumulator holds Q4.28 sums of Q2.14 x Q2.14 products
    localparam int ACC_W = 32;

    // Fraction bits of the Q2.14 coefficient format
    // Result window is acc[FRAC_BITS +: SAMPLE_W], round bit just below it
    localparam int FRAC_BITS = 14;

    typedef logic signed [SAMPLE_W-1:0] sample_t;   // Signed audio sample
    typedef logic signed [ACC_W-1:0] acc_t;         // Q4.28 accumulator word

    // One biquad coefficient set
    // a1 and a2 are stored with their textbook sign; the datapath negates them
    typedef struct packed {
        sample_t b0;    // Feed-forward, x[n]
        sample_t b1;    // Feed-forward, x[n-1]
        sample_t b2;    // Feed-forward, x[n-2]
        sample_t a1;    // Feedback, y[n-1]
        sample_t a2;    // Feedback, y[n-2]
    } biquad_coef_t;

endpackage
